/* design/mips_isa_pkg.sv */
//**************************************************************************
// MIPS I subset encodings. Opcodes and function codes not listed here
// decode as a no-op; there is no reserved-instruction exception.
//**************************************************************************
package mips_isa_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // Same word, two field layouts
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

endpackage

/* design/mips_pipe_pkg.sv */
//**************************************************************************
// Stage register contents. An all-zero value of any stage struct is a
// bubble: no register write, no memory access, no halt.
//**************************************************************************
package mips_pipe_pkg;

    typedef struct packed {
        mips_isa_pkg::instr_u instr;
        logic [31:0]          pc_plus4;
    } if_id_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_to_reg;
        logic                  mem_write;
        logic                  alu_src_imm;
        mips_isa_pkg::alu_op_e alu_op;
        logic                  halt;
    } ctrl_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] rs_val;
        logic [31:0] rt_val;
        logic [31:0] imm_ext;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  write_reg;
    } id_ex_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] alu_result;
        logic [31:0] store_data;
        logic [4:0]  write_reg;
    } ex_mem_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_to_reg;
        logic        halt;
        logic [31:0] alu_result;
        logic [31:0] load_data;
        logic [4:0]  write_reg;
    } mem_wb_t;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_e;

endpackage

/* design/mips_fetch.sv */
//**************************************************************************
// Fetch stage. The instruction read is combinational; once halted the PC
// stays where the halting JR left it and only bubbles enter decode.
//**************************************************************************
`timescale 1ns/1ps

module mips_fetch #(
    parameter logic [31:0] RESET_VECTOR = 32'hBFC00000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clk_enable,
    input  logic                  stall,
    input  logic                  halted,
    input  logic                  pc_redirect,
    input  logic [31:0]           pc_target,
    input  logic [31:0]           instr_readdata,
    output logic [31:0]           instr_address,
    output mips_pipe_pkg::if_id_t if_id
);

    logic [31:0] pc;
    logic [31:0] pc_plus4;

    assign pc_plus4      = pc + 32'd4;
    assign instr_address = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_VECTOR;
        end else if (clk_enable && !stall && !halted) begin
            pc <= pc_redirect ? pc_target : pc_plus4;
        end
    end

    // No delay slot, so the word fetched behind a redirect is dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            if_id <= '0;
        end else if (clk_enable) begin
            if (pc_redirect || halted) begin
                if_id <= '0;
            end else if (!stall) begin
                if_id <= '{instr: instr_readdata, pc_plus4: pc_plus4};
            end
        end
    end

endmodule

/* design/mips_decode.sv */
//**************************************************************************
// Decode stage with the register file. Branches and JR resolve here, so
// their operands must be ready; the hazard unit stalls until they are.
//**************************************************************************
`timescale 1ns/1ps

module mips_decode (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clk_enable,
    input  logic                   stall,
    input  logic                   flush_id_ex,
    input  mips_pipe_pkg::if_id_t  if_id,
    input  logic                   fwd_branch_a,
    input  logic                   fwd_branch_b,
    input  logic [31:0]            mem_alu_result,
    input  logic                   wb_write,
    input  logic [4:0]             wb_reg,
    input  logic [31:0]            wb_result,
    output mips_pipe_pkg::id_ex_t  id_ex,
    output logic                   pc_redirect,
    output logic [31:0]            pc_target,
    output logic [4:0]             rs,
    output logic [4:0]             rt,
    output logic                   uses_rt,
    output logic                   is_branch,
    output logic [31:0]            register_v0
);

    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic [31:0] regs [32];
    instr_u      instr;
    ctrl_t       ctrl;
    logic [4:0]  write_reg;
    logic [31:0] imm_ext;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] cmp_a;
    logic [31:0] cmp_b;
    logic        is_jr;
    logic        taken;

    assign instr = if_id.instr;
    assign rs    = instr.r.rs;
    assign rt    = instr.i.rt;

    always_ff @(posedge clk) begin
        if (clk_enable && wb_write && wb_reg != 5'd0) begin
            regs[wb_reg] <= wb_result;
        end
    end

    // Write-first bypass; $zero reads as 0
    assign rs_val = (rs == 5'd0) ? 32'd0 :
                    (wb_write && wb_reg == rs) ? wb_result : regs[rs];
    assign rt_val = (rt == 5'd0) ? 32'd0 :
                    (wb_write && wb_reg == rt) ? wb_result : regs[rt];

    assign register_v0 = regs[2];

    assign cmp_a = fwd_branch_a ? mem_alu_result : rs_val;
    assign cmp_b = fwd_branch_b ? mem_alu_result : rt_val;

    always_comb begin
        ctrl      = '0;
        write_reg = instr.i.rt;
        imm_ext   = {{16{instr.i.imm[15]}}, instr.i.imm};
        uses_rt   = 1'b0;
        is_branch = 1'b0;
        is_jr     = 1'b0;
        case (instr.r.op)
            OP_SPECIAL: begin
                write_reg      = instr.r.rd;
                uses_rt        = 1'b1;
                ctrl.reg_write = 1'b1;
                case (instr.r.funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_JR: begin
                        ctrl.reg_write = 1'b0;
                        uses_rt        = 1'b0;
                        is_branch      = 1'b1;
                        is_jr          = 1'b1;
                        ctrl.halt      = (cmp_a == 32'd0);
                    end
                    default: begin
                        ctrl.reg_write = 1'b0;
                        uses_rt        = 1'b0;
                    end
                endcase
            end
            OP_ADDIU, OP_ORI, OP_LUI, OP_LW: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                if (instr.r.op == OP_ORI) begin
                    ctrl.alu_op = ALU_OR;
                    imm_ext     = {16'd0, instr.i.imm};
                end else if (instr.r.op == OP_LUI) begin
                    ctrl.alu_op = ALU_LUI;
                end
                ctrl.mem_to_reg = (instr.r.op == OP_LW);
            end
            OP_SW: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                uses_rt          = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                is_branch = 1'b1;
                uses_rt   = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        taken = is_jr ||
                (instr.r.op == OP_BEQ && cmp_a == cmp_b) ||
                (instr.r.op == OP_BNE && cmp_a != cmp_b);
        pc_redirect = taken && !stall;
        pc_target   = is_jr ? cmp_a : if_id.pc_plus4 + {imm_ext[29:0], 2'b00};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex <= '0;
        end else if (clk_enable) begin
            if (flush_id_ex) begin
                id_ex <= '0;
            end else begin
                id_ex <= '{ctrl: ctrl, rs_val: rs_val, rt_val: rt_val, imm_ext: imm_ext,
                           rs: rs, rt: rt, write_reg: write_reg};
            end
        end
    end

endmodule

/* design/mips_hazard.sv */
//**************************************************************************
// Hazard detection and forwarding select. Purely combinational; a stall
// holds fetch and decode and puts a bubble into execute.
//**************************************************************************
`timescale 1ns/1ps

module mips_hazard (
    input  logic [4:0]             rs,
    input  logic [4:0]             rt,
    input  logic                   uses_rt,
    input  logic                   is_branch,
    input  mips_pipe_pkg::id_ex_t  id_ex,
    input  mips_pipe_pkg::ex_mem_t ex_mem,
    input  mips_pipe_pkg::mem_wb_t mem_wb,
    output logic                   stall,
    output logic                   flush_id_ex,
    output mips_pipe_pkg::fwd_e    fwd_a,
    output mips_pipe_pkg::fwd_e    fwd_b,
    output logic                   fwd_branch_a,
    output logic                   fwd_branch_b
);

    import mips_pipe_pkg::*;

    logic ex_writes;
    logic mem_writes;
    logic wb_writes;
    logic dep_ex;
    logic dep_mem;

    // Memory stage wins over writeback when both hold the register
    function automatic fwd_e pick(input logic [4:0] src);
        if (mem_writes && ex_mem.write_reg == src) begin
            return FWD_MEM;
        end else if (wb_writes && mem_wb.write_reg == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    // $zero is never a producer
    assign ex_writes  = id_ex.ctrl.reg_write && id_ex.write_reg != 5'd0;
    assign mem_writes = ex_mem.ctrl.reg_write && ex_mem.write_reg != 5'd0;
    assign wb_writes  = mem_wb.reg_write && mem_wb.write_reg != 5'd0;

    assign dep_ex  = ex_writes &&
                     (id_ex.write_reg == rs || (uses_rt && id_ex.write_reg == rt));
    assign dep_mem = mem_writes &&
                     (ex_mem.write_reg == rs || (uses_rt && ex_mem.write_reg == rt));

    assign stall = (dep_ex && id_ex.ctrl.mem_to_reg) ||
                   (is_branch && (dep_ex || (dep_mem && ex_mem.ctrl.mem_to_reg)));
    assign flush_id_ex = stall;

    assign fwd_branch_a = mem_writes && ex_mem.write_reg == rs;
    assign fwd_branch_b = mem_writes && ex_mem.write_reg == rt;

    always_comb begin
        fwd_a = pick(id_ex.rs);
        fwd_b = pick(id_ex.rt);
    end

endmodule

/* design/mips_execute.sv */
//**************************************************************************
// Execute stage. Arithmetic wraps and never traps; loads never reach the
// memory-stage forward path because of the load-use stall.
//**************************************************************************
`timescale 1ns/1ps

module mips_execute (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clk_enable,
    input  mips_pipe_pkg::id_ex_t  id_ex,
    input  mips_pipe_pkg::fwd_e    fwd_a,
    input  mips_pipe_pkg::fwd_e    fwd_b,
    input  logic [31:0]            wb_result,
    output mips_pipe_pkg::ex_mem_t ex_mem
);

    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic [31:0] op_a;
    logic [31:0] rt_fwd;
    logic [31:0] op_b;
    logic [31:0] result;

    function automatic logic [31:0] fwd_mux(input fwd_e sel, input logic [31:0] reg_val);
        case (sel)
            FWD_MEM: return ex_mem.alu_result;
            FWD_WB:  return wb_result;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        op_a   = fwd_mux(fwd_a, id_ex.rs_val);
        rt_fwd = fwd_mux(fwd_b, id_ex.rt_val);
        op_b   = id_ex.ctrl.alu_src_imm ? id_ex.imm_ext : rt_fwd;
        case (id_ex.ctrl.alu_op)
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SLT: result = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_LUI: result = {op_b[15:0], 16'd0};
            default: result = op_a + op_b;
        endcase
    end

    // Store data is the forwarded rt, not the immediate
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem <= '0;
        end else if (clk_enable) begin
            ex_mem <= '{ctrl: id_ex.ctrl, alu_result: result, store_data: rt_fwd,
                        write_reg: id_ex.write_reg};
        end
    end

endmodule

/* design/mips_mem_wb.sv */
//**************************************************************************
// Memory and writeback. Load data must be valid in the same cycle as
// data_read; there are no wait states.
//**************************************************************************
`timescale 1ns/1ps

module mips_mem_wb (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clk_enable,
    input  mips_pipe_pkg::ex_mem_t ex_mem,
    input  logic [31:0]            data_readdata,
    output logic [31:0]            data_address,
    output logic                   data_write,
    output logic                   data_read,
    output logic [31:0]            data_writedata,
    output mips_pipe_pkg::mem_wb_t mem_wb,
    output logic                   wb_write,
    output logic [4:0]             wb_reg,
    output logic [31:0]            wb_result,
    output logic                   active
);

    assign data_address   = ex_mem.alu_result;
    assign data_writedata = ex_mem.store_data;
    assign data_write     = ex_mem.ctrl.mem_write;
    assign data_read      = ex_mem.ctrl.mem_to_reg;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb <= '0;
        end else if (clk_enable) begin
            mem_wb <= '{reg_write: ex_mem.ctrl.reg_write, mem_to_reg: ex_mem.ctrl.mem_to_reg,
                        halt: ex_mem.ctrl.halt, alu_result: ex_mem.alu_result,
                        load_data: data_readdata, write_reg: ex_mem.write_reg};
        end
    end

    assign wb_write  = mem_wb.reg_write;
    assign wb_reg    = mem_wb.write_reg;
    assign wb_result = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

    // Everything older than the halting JR has retired by now
    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b1;
        end else if (clk_enable && mem_wb.halt) begin
            active <= 1'b0;
        end
    end

endmodule

/* design/mips_cpu.sv */
//**************************************************************************
// Five-stage MIPS I subset CPU on a Harvard bus. clk_enable low freezes
// every register; a JR to address 0 halts and drops active.
//**************************************************************************
`timescale 1ns/1ps

module mips_cpu #(
    parameter logic [31:0] RESET_VECTOR = 32'hBFC00000
) (
    input  logic        clk,
    input  logic        reset,
    output logic        active,
    output logic [31:0] register_v0,
    input  logic        clk_enable,
    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,
    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata
);

    import mips_pipe_pkg::*;

    if_id_t      if_id;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    mem_wb_t     mem_wb;
    fwd_e        fwd_a;
    fwd_e        fwd_b;
    logic        stall;
    logic        flush_id_ex;
    logic        fwd_branch_a;
    logic        fwd_branch_b;
    logic        pc_redirect;
    logic [31:0] pc_target;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic        uses_rt;
    logic        is_branch;
    logic        wb_write;
    logic [4:0]  wb_reg;
    logic [31:0] wb_result;
    logic        halted;

    // Fetch stops as soon as the halting JR has left decode
    assign halted = id_ex.ctrl.halt || ex_mem.ctrl.halt || mem_wb.halt || !active;

    mips_fetch #(
        .RESET_VECTOR(RESET_VECTOR)
    ) fetch_i (
        .clk(clk),
        .reset(reset),
        .clk_enable(clk_enable),
        .stall(stall),
        .halted(halted),
        .pc_redirect(pc_redirect),
        .pc_target(pc_target),
        .instr_readdata(instr_readdata),
        .instr_address(instr_address),
        .if_id(if_id)
    );

    mips_decode decode_i (
        .clk(clk),
        .reset(reset),
        .clk_enable(clk_enable),
        .stall(stall),
        .flush_id_ex(flush_id_ex),
        .if_id(if_id),
        .fwd_branch_a(fwd_branch_a),
        .fwd_branch_b(fwd_branch_b),
        .mem_alu_result(ex_mem.alu_result),
        .wb_write(wb_write),
        .wb_reg(wb_reg),
        .wb_result(wb_result),
        .id_ex(id_ex),
        .pc_redirect(pc_redirect),
        .pc_target(pc_target),
        .rs(rs),
        .rt(rt),
        .uses_rt(uses_rt),
        .is_branch(is_branch),
        .register_v0(register_v0)
    );

    mips_hazard hazard_i (
        .rs(rs),
        .rt(rt),
        .uses_rt(uses_rt),
        .is_branch(is_branch),
        .id_ex(id_ex),
        .ex_mem(ex_mem),
        .mem_wb(mem_wb),
        .stall(stall),
        .flush_id_ex(flush_id_ex),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .fwd_branch_a(fwd_branch_a),
        .fwd_branch_b(fwd_branch_b)
    );

    mips_execute execute_i (
        .clk(clk),
        .reset(reset),
        .clk_enable(clk_enable),
        .id_ex(id_ex),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .wb_result(wb_result),
        .ex_mem(ex_mem)
    );

    mips_mem_wb mem_wb_i (
        .clk(clk),
        .reset(reset),
        .clk_enable(clk_enable),
        .ex_mem(ex_mem),
        .data_readdata(data_readdata),
        .data_address(data_address),
        .data_write(data_write),
        .data_read(data_read),
        .data_writedata(data_writedata),
        .mem_wb(mem_wb),
        .wb_write(wb_write),
        .wb_reg(wb_reg),
        .wb_result(wb_result),
        .active(active)
    );

endmodule

/* tb/mips_tb_program.svh */
//**************************************************************************
// Test program for a reset vector of 0xBFC00000 and data at 0x10000000.
// The JR target built in words 22 and 23 depends on that vector. PROG_LEN must stay 32.
//**************************************************************************
`ifndef MIPS_TB_PROGRAM_SVH
`define MIPS_TB_PROGRAM_SVH

localparam int PROG_LEN = 32;

// Register numbers v0=2 t0=8 t1=9 t2=10 t3=11 t4=12 t5=13 s0=16
localparam logic [31:0] PROGRAM [PROG_LEN] = '{
    32'h3C101000,  // 00 lui   s0, 0x1000
    32'h34080005,  // 01 ori   t0, zero, 5
    32'h25090003,  // 02 addiu t1, t0, 3
    32'h01095021,  // 03 addu  t2, t0, t1
    32'h01485823,  // 04 subu  t3, t2, t0
    32'hAE0B0000,  // 05 sw    t3, 0(s0)
    32'h8E0C0000,  // 06 lw    t4, 0(s0)
    32'h018A6021,  // 07 addu  t4, t4, t2      load-use
    32'hAE0C0004,  // 08 sw    t4, 4(s0)
    32'h8E090004,  // 09 lw    t1, 4(s0)
    32'h112C0002,  // 10 beq   t1, t4, +2      taken, on loaded value
    32'hAE00000C,  // 11 sw    zero, 12(s0)    flushed
    32'h240807FF,  // 12 addiu t0, zero, 0x7ff skipped
    32'h01285026,  // 13 xor   t2, t1, t0
    32'h014C5824,  // 14 and   t3, t2, t4
    32'h01685825,  // 15 or    t3, t3, t0
    32'h2409FFFC,  // 16 addiu t1, zero, -4
    32'h012B402A,  // 17 slt   t0, t1, t3
    32'h250C0014,  // 18 addiu t4, t0, 20
    32'h158B0002,  // 19 bne   t4, t3, +2      not taken
    32'hAE080008,  // 20 sw    t0, 8(s0)
    32'h012B5023,  // 21 subu  t2, t1, t3
    32'h3C0DBFC0,  // 22 lui   t5, 0xbfc0
    32'h35AD0068,  // 23 ori   t5, t5, 0x68
    32'h01A00008,  // 24 jr    t5              to word 26
    32'hAE000010,  // 25 sw    zero, 16(s0)    flushed
    32'hAE0A000C,  // 26 sw    t2, 12(s0)
    32'h8E0B000C,  // 27 lw    t3, 12(s0)
    32'h016C1021,  // 28 addu  v0, t3, t4      load-use
    32'hAE020010,  // 29 sw    v0, 16(s0)
    32'h00000008,  // 30 jr    zero            halt
    32'hAE0B0014   // 31 sw    t3, 20(s0)      flushed
};

localparam int N_STORES = 5;

localparam logic [31:0] EXP_STORE_ADDR [N_STORES] = '{
    32'h10000000, 32'h10000004, 32'h10000008, 32'h1000000C, 32'h10000010
};

// 8, 8+13, slt(-4,21), -4-21, -25+21
localparam logic [31:0] EXP_STORE_DATA [N_STORES] = '{
    32'h00000008, 32'h00000015, 32'h00000001, 32'hFFFFFFE7, 32'hFFFFFFFC
};

localparam int N_LOADS = 3;

// Loads in words 06, 09 and 27
localparam logic [31:0] EXP_LOAD_ADDR [N_LOADS] = '{
    32'h10000000, 32'h10000004, 32'h1000000C
};

localparam logic [31:0] EXP_V0 = 32'hFFFFFFFC;

`endif

/* tb/mips_cpu_tb.sv */
//**************************************************************************
// CPU testbench with zero-wait ROM and RAM models and a random clk_enable.
// Data accesses must fall in the 64-word window at DATA_BASE.
//**************************************************************************
`timescale 1ns/1ps

module mips_cpu_tb;

    localparam logic [31:0] RESET_VECTOR = 32'hBFC00000;
    localparam logic [31:0] DATA_BASE    = 32'h10000000;
    localparam int          RAM_WORDS    = 64;
    localparam int          HALF_PERIOD  = 5;

    `include "mips_tb_program.svh"

    localparam int WATCHDOG_CYCLES = 40 * PROG_LEN;

    logic        clk;
    logic        reset;
    logic        clk_enable;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;
    logic [31:0] ram [RAM_WORDS];
    logic [31:0] lcg_state;
    int          errors = 0;
    int          store_idx = 0;
    int          load_idx = 0;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5A5AC3C3;
    endfunction

    // Outside the program image the ROM reads as a no-op
    function automatic logic [31:0] rom_word(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - RESET_VECTOR;
        if (offset < 32'(4 * PROG_LEN)) begin
            return PROGRAM[offset[6:2]];
        end
        return 32'd0;
    endfunction

    task automatic flag_mismatch(input string msg);
        errors++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    task automatic advance_cycle();
        @(posedge clk);
        #1;
        lcg_state  = lcg_next(lcg_state);
        clk_enable = (lcg_state[31:30] != 2'b00);
    endtask

    mips_cpu #(
        .RESET_VECTOR(RESET_VECTOR)
    ) mips_cpu_i (
        .clk(clk),
        .reset(reset),
        .active(active),
        .register_v0(register_v0),
        .clk_enable(clk_enable),
        .instr_address(instr_address),
        .instr_readdata(instr_readdata),
        .data_address(data_address),
        .data_write(data_write),
        .data_read(data_read),
        .data_writedata(data_writedata),
        .data_readdata(data_readdata)
    );

    assign instr_readdata = rom_word(instr_address);
    assign data_readdata  = ram[data_address[7:2]];

    // Stores and loads are compared in order against the expected tables
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                ram[i] <= fill_word(DATA_BASE + 32'(i) * 32'd4);
            end
            store_idx <= 0;
            load_idx  <= 0;
        end else if (clk_enable) begin
            if (data_write) begin
                assert (store_idx < N_STORES && data_address == EXP_STORE_ADDR[store_idx] &&
                        data_writedata == EXP_STORE_DATA[store_idx])
                    else flag_mismatch($sformatf("store %0d wrote %h to %h", store_idx,
                                                 data_writedata, data_address));
                ram[data_address[7:2]] <= data_writedata;
                store_idx <= store_idx + 1;
            end
            if (data_read) begin
                assert (load_idx < N_LOADS && data_address == EXP_LOAD_ADDR[load_idx])
                    else flag_mismatch($sformatf("load %0d read from %h", load_idx,
                                                 data_address));
                load_idx <= load_idx + 1;
            end
        end
    end

    assert property (@(posedge clk) $fell(reset) |->
                     active && !data_write && !data_read && instr_address == RESET_VECTOR)
        else flag_mismatch("outputs wrong after reset");

    assert property (@(posedge clk) disable iff (reset)
                     (data_write || data_read) |->
                     data_address[1:0] == 2'b00 && data_address[31:8] == DATA_BASE[31:8])
        else flag_mismatch($sformatf("bad data address %h", data_address));

    assert property (@(posedge clk) disable iff (reset) !(data_write && data_read))
        else flag_mismatch("data_write and data_read both high");

    assert property (@(posedge clk) disable iff (reset) !clk_enable |=>
                     $stable(instr_address) && $stable(register_v0) && $stable(active))
        else flag_mismatch("outputs moved while clk_enable was low");

    assert property (@(posedge clk) disable iff (reset) (data_write && !clk_enable) |=>
                     data_write && $stable(data_address) && $stable(data_writedata))
        else flag_mismatch("store strobe changed while clk_enable was low");

    assert property (@(posedge clk) disable iff (reset) !active |=>
                     !active && $stable(instr_address) && !data_write)
        else flag_mismatch("CPU moved after halt");

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 2 * HALF_PERIOD);
        $display("Timeout: active did not fall within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        reset      = 1'b1;
        clk_enable = 1'b1;
        lcg_state  = 32'd38696;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        while (active) begin
            advance_cycle();
        end
        // Keep clocking so the halt checks see enabled and held cycles
        repeat (12) advance_cycle();
        assert (register_v0 == EXP_V0)
            else flag_mismatch($sformatf("register_v0 %h, expected %h", register_v0, EXP_V0));
        assert (store_idx == N_STORES)
            else flag_mismatch($sformatf("%0d stores seen, expected %0d", store_idx, N_STORES));
        assert (load_idx == N_LOADS)
            else flag_mismatch($sformatf("%0d loads seen, expected %0d", load_idx, N_LOADS));
        $display("Checks done: %0d errors, %0d of %0d stores and %0d of %0d loads seen",
                 errors, store_idx, N_STORES, load_idx, N_LOADS);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+tb
design/mips_isa_pkg.sv
design/mips_pipe_pkg.sv
design/mips_fetch.sv
design/mips_decode.sv
design/mips_hazard.sv
design/mips_execute.sv
design/mips_mem_wb.sv
design/mips_cpu.sv
tb/mips_cpu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the CPU testbench with Verilator; status follows sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -j 0 --top-module mips_cpu_tb -f list.f \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vmips_cpu_tb > sim.log 2>&1 || echo "Simulator returned an error"
cat sim.log
grep -q "^TEST RESULT: PASS$" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }
